//--- Bender.yml
package:
  name: ecc_100

sources:
  - files:
      - verilog/ecc_pkg.sv
      - verilog/ecc_encoder.sv
      - verilog/ecc_syndrome_decoder.sv
      - verilog/ecc_check_stage.sv
      - verilog/ecc_100_top.sv

  - target: test
    include_dirs:
      - dv
    files:
      - dv/ecc_100_tb.sv

//--- dv/ecc_tb_model.svh
`ifndef ecc_tb_model_svh
`define ecc_tb_model_svh

// reference model of the SECDED code, built from the Hamming position rule.
// it is included inside the testbench module, after the package import.

function automatic bit is_power_of_two(input int unsigned value);
    return (value != 0) && ((value & (value - 1)) == 0);
endfunction

// data bit index takes the index-th position from 3 upward that is not a power of two.
function automatic int unsigned model_position(input int unsigned index);
    int unsigned candidate;
    int unsigned count;
    candidate = 3;
    count     = 0;
    while (count <= index) begin
        if (!is_power_of_two(candidate)) begin
            if (count == index) begin
                return candidate;
            end
            count++;
        end
        candidate++;
    end
    return 0;
endfunction

// the column of a data bit is the syndrome that a flip of that bit produces.
function automatic parity_t model_column(input int unsigned index);
    int unsigned pos;
    int unsigned ones;
    parity_t     column;
    pos    = model_position(index);
    ones   = 0;
    column = '0;
    for (int unsigned k = 0; k < pos_width; k++) begin
        column[k] = pos[k];
        ones += pos[k];
    end
    // the top check bit covers positions with an even number of ones.
    column[parity_width-1] = ((ones % 2) == 0);
    return column;
endfunction

function automatic parity_t model_parity(input data_t data);
    parity_t parity;
    parity = '0;
    for (int unsigned i = 0; i < data_width; i++) begin
        if (data[i]) begin
            parity ^= model_column(i);
        end
    end
    return parity;
endfunction

function automatic ecc_word_t encode_word(input data_t data);
    ecc_word_t word;
    word.data   = data;
    word.parity = model_parity(data);
    return word;
endfunction

function automatic ecc_result_t expect_clean(input data_t data);
    ecc_result_t res;
    res          = '0;
    res.data     = data;
    return res;
endfunction

// a flipped data bit comes back repaired, with its own bit set in the mask.
function automatic ecc_result_t expect_data_fix(input data_t data, input int unsigned index);
    ecc_result_t res;
    res             = '0;
    res.data        = data;
    res.mask[index] = 1'b1;
    res.sbit_err    = 1'b1;
    return res;
endfunction

function automatic ecc_result_t expect_check_fix(input data_t data);
    ecc_result_t res;
    res          = '0;
    res.data     = data;
    res.sbit_err = 1'b1;
    return res;
endfunction

function automatic ecc_result_t expect_double(input data_t received);
    ecc_result_t res;
    res          = '0;
    res.data     = received;
    res.dbit_err = 1'b1;
    return res;
endfunction

// in bypass only the data and the flags are defined.
function automatic ecc_result_t expect_bypass(input data_t received);
    ecc_result_t res;
    res      = '0;
    res.data = received;
    return res;
endfunction

`endif

//--- dv/ecc_100_tb.sv
module ecc_100_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import ecc_pkg::*;

    `include "ecc_tb_model.svh"

    localparam int unsigned n_encode    = 32;
    localparam int unsigned n_clean     = 24;
    localparam int unsigned n_double    = 18;
    localparam int unsigned n_bypass    = 12;
    localparam int unsigned test_cycles = 3 + n_encode + (n_clean + n_clean / 2 + 1)
                                        + (data_width + 1) + (parity_width + n_double + 1)
                                        + (n_bypass + 1);
    localparam int unsigned watchdog_ns = test_cycles * 100 + 2000;

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    logic        bypass;
    ecc_word_t   in_word;
    parity_t     parity_out;
    logic        out_valid;
    ecc_result_t result;

    int          seed = 32'h4a67;
    int unsigned checks;
    int unsigned value_errors;
    int unsigned protocol_errors;

    // expectation for the word accepted on the previous falling edge.
    logic        have_pending;
    ecc_result_t pending_result;
    logic        pending_mask;

    ecc_100_top dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .bypass     (bypass),
        .in_word    (in_word),
        .parity_out (parity_out),
        .out_valid  (out_valid),
        .result     (result)
    );

    initial clk = 1'b0;

    always #50 clk = ~clk;

    function automatic data_t random_data();
        logic [127:0] wide;
        wide = {$random(seed), $random(seed), $random(seed), $random(seed)};
        return wide[data_width-1:0];
    endfunction

    function automatic int unsigned random_index(input int unsigned range);
        return $unsigned($random(seed)) % range;
    endfunction

    task automatic check_field(input string name, input data_t got, input data_t expected);
        checks++;
        assert (got === expected) else begin
            $display("FAILED %s: got %h, expected %h", name, got, expected);
            value_errors++;
        end
    endtask

    task automatic check_valid(input logic expected);
        checks++;
        assert (out_valid === expected) else begin
            if (expected) begin
                $display("out_valid did not rise one cycle after in_valid");
            end else begin
                $display("out_valid was high without in_valid on the cycle before");
            end
            protocol_errors++;
        end
    endtask

    task automatic compare_result(input ecc_result_t expected, input logic with_mask);
        check_field("result.data", result.data, expected.data);
        if (with_mask) begin
            check_field("result.mask", result.mask, expected.mask);
        end
        check_field("result.sbit_err", data_t'(result.sbit_err), data_t'(expected.sbit_err));
        check_field("result.dbit_err", data_t'(result.dbit_err), data_t'(expected.dbit_err));
    endtask

    // one clock cycle: check what the previous cycle produced, then drive the next input.
    task automatic step(input logic valid, input logic byp, input ecc_word_t word,
                        input ecc_result_t expected, input logic with_mask);
        @(negedge clk);
        check_valid(have_pending);
        if (have_pending && out_valid === 1'b1) begin
            compare_result(pending_result, pending_mask);
        end
        in_valid       = valid;
        bypass         = byp;
        in_word        = word;
        have_pending   = valid;
        pending_result = expected;
        pending_mask   = with_mask;
    endtask

    task automatic idle_cycle();
        step(1'b0, 1'b0, '0, '0, 1'b0);
    endtask

    task automatic test_reset();
        ecc_word_t word;
        word = encode_word(random_data());
        word.data[0] = ~word.data[0];
        @(negedge clk);
        check_valid(1'b0);
        compare_result('0, 1'b1);
        in_valid = 1'b1;
        in_word  = word;
        @(negedge clk);
        check_valid(1'b0);
        compare_result('0, 1'b1);
        arst_n   = 1'b1;
        in_valid = 1'b0;
        @(negedge clk);
        check_valid(1'b0);
        compare_result('0, 1'b1);
    endtask

    task automatic test_encoding();
        data_t     data;
        ecc_word_t word;
        for (int unsigned n = 0; n < n_encode; n++) begin
            if (n == 0) begin
                data = '0;
            end else if (n == 1) begin
                data = '1;
            end else begin
                data = random_data();
            end
            word.data   = data;
            word.parity = '0;
            step(1'b0, 1'b0, word, '0, 1'b0);
            @(posedge clk);
            check_field("parity_out", data_t'(parity_out), data_t'(model_parity(data)));
        end
    endtask

    // every other word is followed by an idle cycle to check the exact latency.
    task automatic test_clean();
        data_t data;
        for (int unsigned n = 0; n < n_clean; n++) begin
            data = random_data();
            step(1'b1, 1'b0, encode_word(data), expect_clean(data), 1'b1);
            if (n % 2 == 1) begin
                idle_cycle();
            end
        end
        idle_cycle();
    endtask

    task automatic test_data_errors();
        data_t     data;
        ecc_word_t word;
        for (int unsigned i = 0; i < data_width; i++) begin
            data = random_data();
            word = encode_word(data);
            word.data[i] = ~word.data[i];
            step(1'b1, 1'b0, word, expect_data_fix(data, i), 1'b1);
        end
        idle_cycle();
    endtask

    task automatic test_check_and_double();
        data_t       data;
        ecc_word_t   word;
        int unsigned a;
        int unsigned b;
        for (int unsigned k = 0; k < parity_width; k++) begin
            data = random_data();
            word = encode_word(data);
            word.parity[k] = ~word.parity[k];
            step(1'b1, 1'b0, word, expect_check_fix(data), 1'b1);
        end
        // pairs of data bits, pairs of check bits, and one of each.
        for (int unsigned n = 0; n < n_double; n++) begin
            data = random_data();
            word = encode_word(data);
            case (n % 3)
                0: begin
                    a = random_index(data_width);
                    b = (a + 1 + random_index(data_width - 1)) % data_width;
                    word.data[a] = ~word.data[a];
                    word.data[b] = ~word.data[b];
                end
                1: begin
                    a = random_index(parity_width);
                    b = (a + 1 + random_index(parity_width - 1)) % parity_width;
                    word.parity[a] = ~word.parity[a];
                    word.parity[b] = ~word.parity[b];
                end
                default: begin
                    a = random_index(data_width);
                    b = random_index(parity_width);
                    word.data[a]   = ~word.data[a];
                    word.parity[b] = ~word.parity[b];
                end
            endcase
            step(1'b1, 1'b0, word, expect_double(word.data), 1'b1);
        end
        idle_cycle();
    endtask

    task automatic test_bypass();
        ecc_word_t   word;
        int unsigned a;
        int unsigned b;
        for (int unsigned n = 0; n < n_bypass; n++) begin
            word = encode_word(random_data());
            a    = random_index(data_width);
            b    = (a + 1 + random_index(data_width - 1)) % data_width;
            if (n % 3 != 0) begin
                word.data[a] = ~word.data[a];
            end
            if (n % 3 == 2) begin
                word.data[b] = ~word.data[b];
            end
            step(1'b1, 1'b1, word, expect_bypass(word.data), 1'b0);
        end
        idle_cycle();
    endtask

    initial begin
        #(watchdog_ns * 1ns);
        $display("watchdog expired after %0d ns before the tests completed", watchdog_ns);
        $display("Verification failed");
        $finish;
    end

    initial begin
        arst_n          = 1'b1;
        in_valid        = 1'b0;
        bypass          = 1'b0;
        in_word         = '0;
        checks          = 0;
        value_errors    = 0;
        protocol_errors = 0;
        have_pending    = 1'b0;
        pending_result  = '0;
        pending_mask    = 1'b0;
        #1 arst_n = 1'b0;

        test_reset();
        test_encoding();
        test_clean();
        test_data_errors();
        test_check_and_double();
        test_bypass();

        $display("checks %0d, value errors %0d, protocol errors %0d",
                 checks, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- verilog/ecc_100_top.sv
module ecc_100_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 in_valid,
    input  logic                 bypass,
    input  ecc_pkg::ecc_word_t   in_word,
    output ecc_pkg::parity_t     parity_out,
    output logic                 out_valid,
    output ecc_pkg::ecc_result_t result
);

    // one encoder serves both the parity output and the syndrome.
    ecc_encoder u_encoder (
        .data   (in_word.data),
        .parity (parity_out)
    );

    ecc_check_stage u_check_stage (
        .clk             (clk),
        .arst_n          (arst_n),
        .in_valid        (in_valid),
        .bypass          (bypass),
        .word            (in_word),
        .computed_parity (parity_out),
        .out_valid       (out_valid),
        .result          (result)
    );

endmodule

//--- verilog/ecc_check_stage.sv
module ecc_check_stage (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 in_valid,
    input  logic                 bypass,
    input  ecc_pkg::ecc_word_t   word,
    input  ecc_pkg::parity_t     computed_parity,
    output logic                 out_valid,
    output ecc_pkg::ecc_result_t result
);

    import ecc_pkg::*;

    ecc_syndrome_u syndrome;
    data_t         mask;
    logic          single_err;
    logic          double_err;
    ecc_result_t   next_result;

    assign syndrome.raw = word.parity ^ computed_parity;

    ecc_syndrome_decoder u_decoder (
        .syndrome   (syndrome),
        .mask       (mask),
        .single_err (single_err),
        .double_err (double_err)
    );

    // the mask is reported even in bypass, it is informational only.
    always_comb begin
        next_result.mask = mask;
        if (bypass) begin
            next_result.data     = word.data;
            next_result.sbit_err = 1'b0;
            next_result.dbit_err = 1'b0;
        end else begin
            next_result.data     = word.data ^ mask;
            next_result.sbit_err = single_err;
            next_result.dbit_err = double_err;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= in_valid;
            // the result holds its last value between valid cycles.
            if (in_valid) begin
                result <= next_result;
            end
        end
    end

    assert property (@(posedge clk) !arst_n |-> !out_valid)
        else $error("out_valid high while in reset");

    // bypass on the input must mask both flags on the registered result.
    assert property (@(posedge clk) disable iff (!arst_n)
        (in_valid && bypass) |=> (!result.sbit_err && !result.dbit_err))
        else $error("error flag raised after a bypass cycle");

endmodule

//--- verilog/ecc_encoder.sv
module ecc_encoder (
    input  ecc_pkg::data_t   data,
    output ecc_pkg::parity_t parity
);

    import ecc_pkg::*;

    // member[k][i] is set when data bit i takes part in check bit k.
    logic [parity_width-1:0][data_width-1:0] member;

    for (genvar i = 0; i < data_width; i++) begin : g_column
        localparam logic [pos_width-1:0] pos = data_pos(i);

        // the position bits give check bits 0 to 6 directly.
        for (genvar k = 0; k < pos_width; k++) begin : g_pos_bit
            assign member[k][i] = pos[k];
        end

        // check bit 7 covers positions with an even number of ones,
        // so every data column ends up with odd weight.
        assign member[parity_width-1][i] = ~(^pos);
    end

    // each check bit is the XOR over the data bits it covers.
    for (genvar k = 0; k < parity_width; k++) begin : g_parity
        assign parity[k] = ^(data & member[k]);
    end

endmodule

//--- verilog/ecc_pkg.sv
package ecc_pkg;

    localparam int unsigned data_width   = 100;
    localparam int unsigned parity_width = 8;
    localparam int unsigned pos_width    = 7;

    typedef logic [data_width-1:0]   data_t;
    typedef logic [parity_width-1:0] parity_t;

    // one received word as it arrives from storage or the link.
    typedef struct packed {
        data_t   data;
        parity_t parity;
    } ecc_word_t;

    typedef struct packed {
        data_t data;
        data_t mask;
        logic  sbit_err;
        logic  dbit_err;
    } ecc_result_t;

    // the low seven bits carry the Hamming position of a flipped bit,
    // the top bit is the overall parity that separates single from double errors.
    typedef union packed {
        logic [parity_width-1:0] raw;
        struct packed {
            logic                 overall;
            logic [pos_width-1:0] pos;
        } fields;
    } ecc_syndrome_u;

    // data bit i sits at the i-th position from 3 upward that is not a power of two.
    // powers of two are the positions of check bits 0 to 6.
    function automatic logic [pos_width-1:0] data_pos(input int unsigned index);
        logic [pos_width-1:0] pos;
        int unsigned          seen;
        pos  = '0;
        seen = 0;
        for (int unsigned p = 3; p < (1 << pos_width); p++) begin
            if ((p & (p - 1)) != 0) begin
                if (seen == index) begin
                    pos = p[pos_width-1:0];
                end
                seen++;
            end
        end
        return pos;
    endfunction

endpackage

//--- verilog/ecc_syndrome_decoder.sv
module ecc_syndrome_decoder (
    input  ecc_pkg::ecc_syndrome_u syndrome,
    output ecc_pkg::data_t         mask,
    output logic                   single_err,
    output logic                   double_err
);

    import ecc_pkg::*;

    logic odd_weight;
    logic nonzero;
    logic check_bit_err;
    logic data_bit_err;

    assign nonzero    = (syndrome.raw != '0);
    assign odd_weight = ^syndrome.raw;

    // a lone set bit means one of the check bits itself flipped.
    assign check_bit_err = nonzero && ((syndrome.raw & (syndrome.raw - 1'b1)) == '0);

    // with odd weight the overall bit already agrees with the column,
    // so matching pos alone identifies the flipped data bit.
    for (genvar i = 0; i < data_width; i++) begin : g_mask
        localparam logic [pos_width-1:0] pos = data_pos(i);

        assign mask[i] = odd_weight && (syndrome.fields.pos == pos);
    end

    assign data_bit_err = |mask;

    assign single_err = check_bit_err || data_bit_err;

    // even weight, or odd weight at a position no data bit owns.
    assign double_err = nonzero && (!odd_weight || (!check_bit_err && !data_bit_err));

    always_comb begin
        assert final (!(single_err && double_err))
            else $error("single and double error flagged together");
        assert final ((mask & (mask - 1'b1)) == '0)
            else $error("correction mask has more than one bit set");
        assert final (!double_err || (mask == '0))
            else $error("double error reported with a nonzero mask");
    end

endmodule

//--- vlog.f
+incdir+dv
verilog/ecc_pkg.sv
verilog/ecc_encoder.sv
verilog/ecc_syndrome_decoder.sv
verilog/ecc_check_stage.sv
verilog/ecc_100_top.sv
dv/ecc_100_tb.sv
